// ==== common/gameport_pkg.sv ====
`default_nettype none

package gameport_pkg;

	// button mode select from the host side
	typedef enum logic [1:0] {
		STD2        = 2'd0,
		FOUR_BUTTON = 2'd1,
		GRAVIS      = 2'd2
	} mode_e;

	// bit positions inside the 14-bit digital button word
	// a set bit means the button is held
	parameter logic [3:0] DIG_RIGHT  = 4'd0;
	parameter logic [3:0] DIG_LEFT   = 4'd1;
	parameter logic [3:0] DIG_DOWN   = 4'd2;
	parameter logic [3:0] DIG_UP     = 4'd3;
	parameter logic [3:0] DIG_B1     = 4'd4;
	parameter logic [3:0] DIG_B2     = 4'd5;
	parameter logic [3:0] DIG_B3     = 4'd6;
	parameter logic [3:0] DIG_B4     = 4'd7;
	parameter logic [3:0] DIG_START  = 4'd8;
	parameter logic [3:0] DIG_SELECT = 4'd9;
	parameter logic [3:0] DIG_R1     = 4'd10;
	parameter logic [3:0] DIG_L1     = 4'd11;
	parameter logic [3:0] DIG_R2     = 4'd12;
	parameter logic [3:0] DIG_L2     = 4'd13;

	// axis one-shot count width and load values
	parameter int unsigned AXIS_W = 9;
	parameter logic [AXIS_W-1:0] AXIS_MIN    = 9'd8;
	parameter logic [AXIS_W-1:0] AXIS_CENTER = 9'd200;
	parameter logic [AXIS_W-1:0] AXIS_MAX    = 9'd391;
	// close to centre so a stick reads as present before the first write
	parameter logic [AXIS_W-1:0] AXIS_RESET  = 9'd197;

	// gravis gamepad pro serial frame length in bits
	parameter int unsigned GRAVIS_FRAME_LEN = 24;

endpackage

`default_nettype wire

// ==== gameport/axis_oneshot.sv ====
`default_nettype none

// one analog axis of the game port
// the count is loaded by a port write and runs down on the shared tick,
// the host times how long the axis bit stays high
module axis_oneshot
	import gameport_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst_n,
	// write strobe from the host, loads a new count
	input  wire logic              fire,
	// count to load, already scaled by the core
	input  wire logic [AXIS_W-1:0] load_value,
	// prescaler pulse, one per count step
	input  wire logic              tick,
	// high while the count is still running
	output logic                   active
);

	// remaining ticks until the axis bit drops
	logic [AXIS_W-1:0] count;
	logic              count_zero;

	assign count_zero = (count == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// start near centre so the axis looks connected
			count <= AXIS_RESET;
		end else if (fire) begin
			// a new write always restarts the one-shot,
			// even if a tick lands in the same cycle
			count <= load_value;
		end else if (tick && !count_zero) begin
			count <= count - 1'b1;
		end
	end

	// decoded straight from the register,
	// valid one cycle after the fire pulse
	assign active = !count_zero;

endmodule

`default_nettype wire

// ==== gameport/gameport_core.sv ====
`default_nettype none

// game port function block
// four axis one-shots on a shared prescaler, the gravis serial encoder and
// the button mux, all folded into the status byte
module gameport_core
	import gameport_pkg::*;
#(
	// prescaler terminal count, one axis step every TICK_DIV+1 cycles
	parameter int TICK_DIV   = 265,
	parameter int GRAVIS_DIV = 2262
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [13:0] dig_1,
	input  wire logic [13:0] dig_2,
	// low byte is X, high byte is Y, both signed
	input  wire logic [15:0] ana_1,
	input  wire logic [15:0] ana_2,
	input  wire logic [1:0]  mode,
	input  wire logic        fire,
	output logic [7:0]       status_now
);

	localparam int PRESC_W = (TICK_DIV > 0) ? $clog2(TICK_DIV + 1) : 1;

	mode_e              mode_sel;
	logic [PRESC_W-1:0] presc;
	logic               tick;
	// axis order is X1, Y1, X2, Y2
	logic [3:0][AXIS_W-1:0] load_value;
	logic [3:0]         axis_active;
	logic               gclk;
	logic [1:0]         gdata;
	// b4 b3 b2 b1, low means pressed on the port
	logic [3:0]         btn;

	// count for one axis
	// an analog deflection wins, scaled by 1.5 around centre,
	// otherwise the digital directions pick one of three fixed points
	function automatic logic [AXIS_W-1:0] axis_load(input logic [7:0] raw,
			input logic to_min, input logic to_max);
		logic [AXIS_W-1:0] ext;
		logic [AXIS_W-1:0] val;
		ext = AXIS_W'($signed(raw));
		// arithmetic half, wraps modulo 512 like the count register
		val = ext + {ext[AXIS_W-1], ext[AXIS_W-1:1]} + AXIS_CENTER;
		if (raw != 8'd0)
			return val;
		else if (to_min)
			return AXIS_MIN;
		else if (to_max)
			return AXIS_MAX;
		else
			return AXIS_CENTER;
	endfunction

	assign mode_sel = mode_e'(mode);

	// prescaler, restarted by every write so the axes start in phase
	assign tick = (presc == PRESC_W'(TICK_DIV));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			presc <= '0;
		else if (fire || tick)
			presc <= '0;
		else
			presc <= presc + 1'b1;
	end

	// left and up go to the short end of the range
	assign load_value[0] = axis_load(ana_1[7:0],  dig_1[DIG_LEFT], dig_1[DIG_RIGHT]);
	assign load_value[1] = axis_load(ana_1[15:8], dig_1[DIG_UP],   dig_1[DIG_DOWN]);
	assign load_value[2] = axis_load(ana_2[7:0],  dig_2[DIG_LEFT], dig_2[DIG_RIGHT]);
	assign load_value[3] = axis_load(ana_2[15:8], dig_2[DIG_UP],   dig_2[DIG_DOWN]);

	for (genvar i = 0; i < 4; i++) begin : g_axis
		axis_oneshot axis_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.fire       (fire),
			.load_value (load_value[i]),
			.tick       (tick),
			.active     (axis_active[i])
		);
	end

	gravis_frame_tx #(
		.GRAVIS_DIV (GRAVIS_DIV)
	) gravis_i (
		.clk   (clk),
		.rst_n (rst_n),
		.dig_1 (dig_1),
		.dig_2 (dig_2),
		.gclk  (gclk),
		.gdata (gdata)
	);

	// button mux, registered once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn <= 4'b1111;
		end else begin
			case (mode_sel)
				// serial pad, clock on b1/b3 and data on b2/b4
				GRAVIS:      btn <= {gdata[1], gclk, gdata[0], gclk};
				FOUR_BUTTON: btn <= ~{dig_1[DIG_B4], dig_1[DIG_B3], dig_1[DIG_B2], dig_1[DIG_B1]};
				// two sticks, also the fallback for the unused code 3
				default:     btn <= ~{dig_2[DIG_B2], dig_2[DIG_B1], dig_1[DIG_B2], dig_1[DIG_B1]};
			endcase
		end
	end

	assign status_now = {btn, axis_active[3], axis_active[2], axis_active[1], axis_active[0]};

endmodule

`default_nettype wire

// ==== gameport/gravis_frame_tx.sv ====
`default_nettype none

// serial encoder for the gravis gamepad pro
// gclk runs at about 20 kHz with the default divider, gdata changes on the
// rising edge and the host samples it on the falling edge
// bit 0 of gdata is player 1, bit 1 is player 2
module gravis_frame_tx
	import gameport_pkg::*;
#(
	// half period of gclk in cycles, minus one
	parameter int GRAVIS_DIV = 2262
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [13:0] dig_1,
	input  wire logic [13:0] dig_2,
	output logic             gclk,
	output logic [1:0]       gdata
);

	localparam int DIV_W = (GRAVIS_DIV > 0) ? $clog2(GRAVIS_DIV + 1) : 1;
	localparam int POS_W = $clog2(GRAVIS_FRAME_LEN);

	logic [DIV_W-1:0] div_cnt;
	logic [POS_W-1:0] pos;
	logic             half_done;
	logic             rise;

	// frame bit for one player at a given position
	// header is 0 then five 1s, each button group is led by a 0
	function automatic logic frame_bit(input logic [POS_W-1:0] p, input logic [13:0] dig);
		logic b;
		case (p)
			5'd1, 5'd2, 5'd3, 5'd4, 5'd5: b = 1'b1;
			// first group
			5'd7:  b = dig[DIG_SELECT];
			5'd8:  b = dig[DIG_START];
			5'd9:  b = dig[DIG_R2];
			5'd10: b = dig[DIG_B4];
			// second group
			5'd12: b = dig[DIG_L2];
			5'd13: b = dig[DIG_B2];
			5'd14: b = dig[DIG_B1];
			5'd15: b = dig[DIG_B3];
			// third group
			5'd17: b = dig[DIG_L1];
			5'd18: b = dig[DIG_R1];
			5'd19: b = dig[DIG_UP];
			5'd20: b = dig[DIG_DOWN];
			// last group has two bits only
			5'd22: b = dig[DIG_RIGHT];
			5'd23: b = dig[DIG_LEFT];
			// position 0 and the separators 6, 11, 16, 21
			default: b = 1'b0;
		endcase
		return b;
	endfunction

	assign half_done = (div_cnt == DIV_W'(GRAVIS_DIV));
	// gclk about to go high
	assign rise = half_done && !gclk;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			gclk    <= 1'b0;
		end else if (half_done) begin
			div_cnt <= '0;
			gclk    <= !gclk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// data and position move together with the rising edge of gclk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos   <= '0;
			gdata <= 2'b00;
		end else if (rise) begin
			gdata <= {frame_bit(pos, dig_2), frame_bit(pos, dig_1)};
			if (pos == POS_W'(GRAVIS_FRAME_LEN - 1))
				pos <= '0;
			else
				pos <= pos + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
common/gameport_pkg.sv
gameport/axis_oneshot.sv
gameport/gravis_frame_tx.sv
gameport/gameport_core.sv
src/io_req_ack.sv
src/gameport_top.sv
test/gameport_assert.sv
test/tb_gameport.sv

// ==== src/gameport_top.sv ====
`default_nettype none

// pc game port controller
// host handshake in front of the game port core
module gameport_top #(
	parameter int TICK_DIV   = 265,
	parameter int GRAVIS_DIV = 2262
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	// host side
	input  wire logic        req,
	input  wire logic        we,
	input  wire logic [1:0]  mode,
	output logic             ack,
	output logic [7:0]       status,
	// game devices
	input  wire logic [13:0] dig_1,
	input  wire logic [13:0] dig_2,
	input  wire logic [15:0] ana_1,
	input  wire logic [15:0] ana_2
);

	logic       fire;
	logic       rd_stb;
	logic [7:0] status_now;

	io_req_ack req_ack_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.we         (we),
		.ack        (ack),
		.status     (status),
		.fire       (fire),
		.rd_stb     (rd_stb),
		.status_now (status_now)
	);

	gameport_core #(
		.TICK_DIV   (TICK_DIV),
		.GRAVIS_DIV (GRAVIS_DIV)
	) core_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.dig_1      (dig_1),
		.dig_2      (dig_2),
		.ana_1      (ana_1),
		.ana_2      (ana_2),
		.mode       (mode),
		.fire       (fire),
		.status_now (status_now)
	);

endmodule

`default_nettype wire

// ==== src/io_req_ack.sv ====
`default_nettype none

// four-phase req/ack slave for the port
// a request gives one strobe, ack then stays up until the host lets go
module io_req_ack (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       req,
	// high for a write, sampled with req
	input  wire logic       we,
	output logic            ack,
	// read data, held while ack is high
	output logic [7:0]      status,
	output logic            fire,
	output logic            rd_stb,
	input  wire logic [7:0] status_now
);

	typedef enum logic [1:0] {
		IDLE,
		ACK_HIGH,
		WAIT_RELEASE
	} state_e;

	state_e state;
	logic   accept;

	// strobes come out in the cycle req is seen, ack follows on the edge
	assign accept = (state == IDLE) && req;
	assign fire   = accept && we;
	assign rd_stb = accept && !we;
	assign ack    = (state != IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:         if (req) state <= ACK_HIGH;
				// first ack cycle, a short req may already be gone
				ACK_HIGH:     state <= req ? WAIT_RELEASE : IDLE;
				WAIT_RELEASE: if (!req) state <= IDLE;
				default:      state <= IDLE;
			endcase
		end
	end

	// capture on the same edge that raises ack, so data is valid with ack
	always_ff @(posedge clk) begin
		if (rd_stb)
			status <= status_now;
	end

endmodule

`default_nettype wire

// ==== test/gameport_assert.sv ====
`default_nettype none

// checker for the game port controller, bound into gameport_top
// handshake rules, axis run length, button mapping and gravis framing
module gameport_assert
	import gameport_pkg::*;
#(
	parameter int TICK_DIV = 265
) (
	input wire logic        clk,
	input wire logic        rst_n,
	input wire logic        req,
	input wire logic        we,
	input wire logic [1:0]  mode,
	input wire logic        ack,
	input wire logic [7:0]  status,
	input wire logic [13:0] dig_1,
	input wire logic [13:0] dig_2,
	input wire logic [15:0] ana_1,
	input wire logic [15:0] ana_2,
	input wire logic        fire,
	input wire logic        rd_stb,
	input wire logic [7:0]  status_now
);
	timeunit 1ns;
	timeprecision 1ps;

	// cycles per axis step
	localparam int TICK_LEN = TICK_DIV + 1;
	// digital bit carried at each frame position
	// -1 stands for a fixed 0 and -2 for a fixed 1
	localparam int FRAME_SRC [24] = '{-1, -2, -2, -2, -2, -2,
		-1, DIG_SELECT, DIG_START, DIG_R2, DIG_B4,
		-1, DIG_L2, DIG_B2, DIG_B1, DIG_B3,
		-1, DIG_L1, DIG_R1, DIG_UP, DIG_DOWN,
		-1, DIG_RIGHT, DIG_LEFT};

	int         fail_cnt = 0;
	int         since_rst;
	int         exp_load [4];
	int         run_len [4];
	logic [3:0] armed;
	// host side view of the serial pad, b1 is the clock
	logic       b1_q;
	logic       seen_rise;
	logic       gsync;
	int         gpos;

	task automatic report_failure(input string what);
		$error("%s", what);
		fail_cnt++;
	endtask

	// 1.5 times the signed byte plus centre, else a fixed point from the directions
	function automatic int expected_load(input logic [7:0] raw, input logic to_min,
			input logic to_max);
		int b;
		b = int'($signed(raw));
		if (b != 0)
			return (b + (b >>> 1) + int'(AXIS_CENTER) + 512) % 512;
		if (to_min)
			return int'(AXIS_MIN);
		if (to_max)
			return int'(AXIS_MAX);
		return int'(AXIS_CENTER);
	endfunction

	function automatic logic frame_bit(input int p, input logic [13:0] d);
		int src;
		src = FRAME_SRC[p];
		if (src < 0)
			return src == -2;
		return d[src];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			since_rst <= 0;
			armed     <= '0;
			b1_q      <= 1'b1;
			seen_rise <= 1'b0;
			gsync     <= 1'b1;
			gpos      <= 0;
		end else begin
			if (since_rst < 64)
				since_rst <= since_rst + 1;
			// a write latches what each axis should load
			if (fire) begin
				exp_load[0] <= expected_load(ana_1[7:0], dig_1[DIG_LEFT], dig_1[DIG_RIGHT]);
				exp_load[1] <= expected_load(ana_1[15:8], dig_1[DIG_UP], dig_1[DIG_DOWN]);
				exp_load[2] <= expected_load(ana_2[7:0], dig_2[DIG_LEFT], dig_2[DIG_RIGHT]);
				exp_load[3] <= expected_load(ana_2[15:8], dig_2[DIG_UP], dig_2[DIG_DOWN]);
				armed       <= 4'hf;
				run_len     <= '{default: 0};
			end else begin
				for (int i = 0; i < 4; i++) begin
					if (status_now[i])
						run_len[i] <= run_len[i] + 1;
					else
						armed[i] <= 1'b0;
				end
			end
			// frame position only holds if gravis mode was set through reset
			if (mode != GRAVIS)
				gsync <= 1'b0;
			b1_q <= status_now[4];
			if (!b1_q && status_now[4])
				seen_rise <= 1'b1;
			if (seen_rise && b1_q && !status_now[4])
				gpos <= (gpos == GRAVIS_FRAME_LEN - 1) ? 0 : gpos + 1;
		end
	end

	a_ack_reset: assert property (@(posedge clk) !rst_n |-> !ack)
		else report_failure("ack high while in reset");

	a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req && (fire || rd_stb)))
		else report_failure("ack rose without a request and its strobe");

	a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ack) |-> !$past(req))
		else report_failure("ack dropped while req was still high");

	a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		(fire || rd_stb) |-> req && !ack && (fire == we) && !(fire && rd_stb))
		else report_failure("strobe outside an accepted request");

	a_status_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ack && $past(ack) |-> $stable(status))
		else report_failure("read data moved while ack was high");

	// nothing pressed and axes still on their reset count
	a_reset_read: assert property (@(posedge clk) disable iff (!rst_n)
		rd_stb && since_rst < 32 |=> status == 8'hff)
		else report_failure("status read after reset is not all ones");

	a_btn_std2: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && $past(mode) == STD2 |-> status_now[7:4] ==
		~{$past(dig_2[DIG_B2]), $past(dig_2[DIG_B1]), $past(dig_1[DIG_B2]), $past(dig_1[DIG_B1])})
		else report_failure("mode 0 button bits wrong");

	a_btn_four: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && $past(mode) == FOUR_BUTTON |-> status_now[7:4] ==
		~{$past(dig_1[DIG_B4]), $past(dig_1[DIG_B3]), $past(dig_1[DIG_B2]), $past(dig_1[DIG_B1])})
		else report_failure("mode 1 button bits wrong");

	// b2 and b4 sampled on the falling edge of b1
	a_gravis: assert property (@(posedge clk) disable iff (!rst_n)
		gsync && seen_rise && b1_q && !status_now[4] |->
		status_now[5] == frame_bit(gpos, dig_1) && status_now[7] == frame_bit(gpos, dig_2))
		else report_failure($sformatf("gravis frame bit %0d wrong", gpos));

	for (genvar i = 0; i < 4; i++) begin : g_axis
		a_axis_run: assert property (@(posedge clk) disable iff (!rst_n)
			armed[i] && !status_now[i] |->
			run_len[i] >= (exp_load[i] - 1) * TICK_LEN &&
			run_len[i] <= (exp_load[i] + 1) * TICK_LEN)
			else report_failure($sformatf("axis %0d ran %0d cycles for load %0d",
				i, run_len[i], exp_load[i]));
	end

endmodule

bind gameport_top gameport_assert #(
	.TICK_DIV (TICK_DIV)
) assert_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.req        (req),
	.we         (we),
	.mode       (mode),
	.ack        (ack),
	.status     (status),
	.dig_1      (dig_1),
	.dig_2      (dig_2),
	.ana_1      (ana_1),
	.ana_2      (ana_2),
	.fire       (fire),
	.rd_stb     (rd_stb),
	.status_now (status_now)
);

`default_nettype wire

// ==== test/tb_gameport.sv ====
`default_nettype none

// testbench for the game port controller
// drives the host handshake and the game devices for the bound checker
module tb_gameport
	import gameport_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICK_DIV   = 3;
	localparam int GRAVIS_DIV = 5;
	localparam int CLK_NS     = 8;
	localparam int N_DIG      = 4;
	localparam int N_ANA      = 3;
	localparam int N_BTN      = 16;
	localparam int N_GRAV     = 2;
	localparam int HS_LIMIT   = 16;
	// longest axis run with the write and polling reads around it
	localparam int AXIS_CYC   = (int'(AXIS_MAX) + 2) * (TICK_DIV + 1) + 40;
	// reset and three frames of the serial pad
	localparam int GRAV_CYC   = 3 * GRAVIS_FRAME_LEN * 2 * (GRAVIS_DIV + 1) + 20;
	localparam int TOTAL_CYC  = 100 + (N_DIG + N_ANA) * AXIS_CYC + 2 * N_BTN * 4
		+ N_GRAV * GRAV_CYC;

	logic        clk   = 1'b0;
	logic        rst_n = 1'b0;
	logic        req   = 1'b0;
	logic        we    = 1'b0;
	logic [1:0]  mode  = 2'd0;
	logic [13:0] dig_1 = '0;
	logic [13:0] dig_2 = '0;
	logic [15:0] ana_1 = '0;
	logic [15:0] ana_2 = '0;
	logic        ack;
	logic [7:0]  status;

	logic [31:0] lcg_state = 32'd1;
	int          stall_cnt = 0;
	int          fail_mark = 0;
	int          tests_ok  = 0;
	int          tests_bad = 0;

	gameport_top #(
		.TICK_DIV   (TICK_DIV),
		.GRAVIS_DIV (GRAVIS_DIV)
	) dut_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.we     (we),
		.mode   (mode),
		.ack    (ack),
		.status (status),
		.dig_1  (dig_1),
		.dig_2  (dig_2),
		.ana_1  (ana_1),
		.ana_2  (ana_2)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// return the upper half of the state since the low bits of an lcg repeat quickly
	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	// both bytes nonzero so the analog path always wins
	function automatic logic [15:0] analog_word();
		logic [15:0] w;
		w = lcg_next();
		if (w[7:0] == 8'h00)
			w[7:0] = 8'h01;
		if (w[15:8] == 8'h00)
			w[15:8] = 8'h80;
		return w;
	endfunction

	// ack is looked at mid-cycle where it is settled
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (ack !== level) begin
			$display("handshake stalled, ack did not reach %0b within %0d cycles",
				level, HS_LIMIT);
			stall_cnt++;
		end
	endtask

	// one full four-phase transfer
	task automatic host_access(input logic write, output logic [7:0] data);
		@(posedge clk);
		req <= 1'b1;
		we  <= write;
		wait_ack(1'b1);
		data = status;
		@(posedge clk);
		req <= 1'b0;
		wait_ack(1'b0);
	endtask

	// poll the status byte until all four axis bits have dropped
	task automatic wait_axes_idle();
		logic [7:0] s;
		int         n;
		s = 8'hff;
		n = 0;
		while (s[3:0] != 4'h0 && n < AXIS_CYC / 4) begin
			host_access(1'b0, s);
			n++;
		end
		if (s[3:0] != 4'h0) begin
			$display("axis one-shots still running after %0d reads", n);
			stall_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = dut_i.assert_i.fail_cnt + stall_cnt - fail_mark;
		fail_mark = fail_mark + errs;
		if (errs == 0) begin
			tests_ok++;
			$display("%0t %s: ok", $time, name);
		end else begin
			tests_bad++;
			$display("ERR %0t %s: %0d check failures", $time, name, errs);
		end
	endtask

	initial begin
		logic [7:0] s;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// two reads inside the reset window with nothing pressed
		host_access(1'b0, s);
		host_access(1'b0, s);
		finish_test("reset state and handshake");

		// first round with no direction held loads the centre
		for (int r = 0; r < N_DIG; r++) begin
			@(posedge clk);
			dig_1 <= (r == 0) ? 14'h0 : 14'(lcg_next());
			dig_2 <= (r == 0) ? 14'h0 : 14'(lcg_next());
			host_access(1'b1, s);
			wait_axes_idle();
		end
		finish_test("digital axes");

		for (int r = 0; r < N_ANA; r++) begin
			@(posedge clk);
			ana_1 <= analog_word();
			ana_2 <= analog_word();
			host_access(1'b1, s);
			wait_axes_idle();
		end
		@(posedge clk);
		ana_1 <= '0;
		ana_2 <= '0;
		finish_test("analog axes");

		for (int m = 0; m < 2; m++) begin
			@(posedge clk);
			mode <= 2'(m);
			for (int k = 0; k < N_BTN; k++) begin
				@(posedge clk);
				dig_1 <= 14'(lcg_next());
				dig_2 <= 14'(lcg_next());
				repeat (2) @(posedge clk);
			end
		end
		finish_test("button modes 0 and 1");

		// reset with gravis selected so the frame starts at position 0
		for (int g = 0; g < N_GRAV; g++) begin
			@(posedge clk);
			mode  <= GRAVIS;
			dig_1 <= 14'(lcg_next());
			dig_2 <= 14'(lcg_next());
			rst_n <= 1'b0;
			repeat (3) @(posedge clk);
			rst_n <= 1'b1;
			repeat (GRAV_CYC) @(posedge clk);
		end
		// let the last clock edges settle before the final count
		repeat (4) @(negedge clk);
		finish_test("gravis frames");

		$display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// sum of all test lengths plus some slack
	initial begin
		#((TOTAL_CYC + 500) * CLK_NS);
		$display("timeout, the run did not end within %0d cycles", TOTAL_CYC + 500);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
